//--- Bender.yml
package:
  name: instr_decoder

sources:
  - hw/decode_pkg.sv
  - hw/decode_int.sv
  - hw/decode_ctrl.sv
  - hw/decode_mem.sv
  - hw/instr_decoder.sv
  - target: simulation
    files:
      - sim/clock_gen.sv
      - sim/tb_instr_decoder.sv

//--- hw/decode_ctrl.sv
// Combinational decoder for JAL, JALR and conditional branches into the ctrl pipe
`timescale 1ns/1ps

module decode_ctrl (
    input  decode_pkg::instr_t       instr,
    output decode_pkg::unit_result_s res
);

    decode_pkg::opcode_t opcode;
    decode_pkg::funct3_t funct3;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    always_comb begin
        res = '0;
        case (opcode)
            decode_pkg::op_jal: begin
                res.hit              = 1'b1;
                res.ctrl.pipe_ctrl_v = 1'b1;
                res.ctrl.irf_w_v     = 1'b1;
                res.ctrl.fu_op       = decode_pkg::ctrl_op_jal;
                res.ctrl.baddr_sel   = decode_pkg::baddr_is_pc;
            end
            decode_pkg::op_jalr: begin
                res.hit              = 1'b1;
                res.illegal          = (funct3 != decode_pkg::f3_jalr);
                res.ctrl.pipe_ctrl_v = 1'b1;
                res.ctrl.irf_w_v     = 1'b1;
                res.ctrl.fu_op       = decode_pkg::ctrl_op_jalr;
                res.ctrl.baddr_sel   = decode_pkg::baddr_is_rs1;
            end
            decode_pkg::op_branch: begin
                res.hit              = 1'b1;
                res.ctrl.pipe_ctrl_v = 1'b1;
                res.ctrl.baddr_sel   = decode_pkg::baddr_is_pc;
                case (funct3)
                    decode_pkg::f3_beq:  res.ctrl.fu_op = decode_pkg::ctrl_op_beq;
                    decode_pkg::f3_bne:  res.ctrl.fu_op = decode_pkg::ctrl_op_bne;
                    decode_pkg::f3_blt:  res.ctrl.fu_op = decode_pkg::ctrl_op_blt;
                    decode_pkg::f3_bge:  res.ctrl.fu_op = decode_pkg::ctrl_op_bge;
                    decode_pkg::f3_bltu: res.ctrl.fu_op = decode_pkg::ctrl_op_bltu;
                    decode_pkg::f3_bgeu: res.ctrl.fu_op = decode_pkg::ctrl_op_bgeu;
                    default:             res.illegal    = 1'b1;
                endcase
            end
            default: ;
        endcase
    end

endmodule

//--- hw/decode_int.sv
// Combinational decoder for OP, OP-32, OP-IMM, OP-IMM-32, LUI and AUIPC with mul/div routing
`timescale 1ns/1ps

module decode_int (
    input  decode_pkg::instr_t       instr,
    output decode_pkg::unit_result_s res
);

    decode_pkg::opcode_t opcode;
    decode_pkg::funct3_t funct3;
    decode_pkg::funct7_t funct7;
    decode_pkg::funct7_t shift_f7;
    decode_pkg::fu_op_t  alu_op;
    logic                is_reg;
    logic                is_word;
    logic                alt;
    logic                f7_is_op;
    logic                f7_ok;
    logic                word_ok;
    logic                alu_ok;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign is_reg  = (opcode == decode_pkg::op_op) || (opcode == decode_pkg::op_op_32);
    assign is_word = (opcode == decode_pkg::op_op_32) || (opcode == decode_pkg::op_imm_32);

    // OP-IMM shifts use a 6-bit shamt, so bit 25 is not part of the function code
    assign shift_f7 = (opcode == decode_pkg::op_imm) ? {funct7[6:1], 1'b0} : funct7;
    assign alt      = (shift_f7 == decode_pkg::funct7_alt);

    always_comb begin
        case (funct3)
            decode_pkg::f3_add_sub: begin
                alu_op = (is_reg && alt) ? decode_pkg::int_op_sub : decode_pkg::int_op_add;
            end
            decode_pkg::f3_sll:  alu_op = decode_pkg::int_op_sll;
            decode_pkg::f3_slt:  alu_op = decode_pkg::int_op_slt;
            decode_pkg::f3_sltu: alu_op = decode_pkg::int_op_sltu;
            decode_pkg::f3_xor:  alu_op = decode_pkg::int_op_xor;
            decode_pkg::f3_or:   alu_op = decode_pkg::int_op_or;
            decode_pkg::f3_and:  alu_op = decode_pkg::int_op_and;
            default:             alu_op = alt ? decode_pkg::int_op_sra : decode_pkg::int_op_srl;
        endcase
    end

    // Upper bits are a function code for register ops and shifts, an immediate otherwise
    assign f7_is_op = is_reg || (funct3 == decode_pkg::f3_sll)
                      || (funct3 == decode_pkg::f3_srl_sra);
    assign f7_ok    = (shift_f7 == decode_pkg::funct7_base)
                      || (alt && ((funct3 == decode_pkg::f3_srl_sra)
                                  || (is_reg && funct3 == decode_pkg::f3_add_sub)));
    assign word_ok  = (funct3 == decode_pkg::f3_add_sub) || (funct3 == decode_pkg::f3_sll)
                      || (funct3 == decode_pkg::f3_srl_sra);
    assign alu_ok   = (~f7_is_op || f7_ok) && (~is_word || word_ok);

    always_comb begin
        res = '0;
        case (opcode)
            decode_pkg::op_op, decode_pkg::op_op_32, decode_pkg::op_imm,
            decode_pkg::op_imm_32: begin
                res.hit           = 1'b1;
                res.ctrl.opw_v    = is_word;
                res.ctrl.src1_sel = decode_pkg::src1_is_rs1;
                res.ctrl.src2_sel = is_reg ? decode_pkg::src2_is_rs2 : decode_pkg::src2_is_imm;
                if (is_reg && funct7 == decode_pkg::funct7_muldiv) begin
                    case (funct3)
                        decode_pkg::f3_mul:  res.ctrl.fu_op = decode_pkg::mul_op_mul;
                        decode_pkg::f3_div:  res.ctrl.fu_op = decode_pkg::mul_op_div;
                        decode_pkg::f3_divu: res.ctrl.fu_op = decode_pkg::mul_op_divu;
                        decode_pkg::f3_rem:  res.ctrl.fu_op = decode_pkg::mul_op_rem;
                        decode_pkg::f3_remu: res.ctrl.fu_op = decode_pkg::mul_op_remu;
                        default:             res.illegal    = 1'b1;
                    endcase
                    res.ctrl.pipe_mul_v  = (funct3 == decode_pkg::f3_mul);
                    // Divide and remainder write back out of band
                    res.ctrl.pipe_long_v = funct3[2];
                    res.ctrl.irf_w_v     = (funct3 == decode_pkg::f3_mul);
                end else begin
                    res.ctrl.pipe_int_v = 1'b1;
                    res.ctrl.irf_w_v    = 1'b1;
                    res.ctrl.fu_op      = alu_op;
                    res.illegal         = ~alu_ok;
                end
            end
            decode_pkg::op_lui: begin
                res.hit             = 1'b1;
                res.ctrl.pipe_int_v = 1'b1;
                res.ctrl.irf_w_v    = 1'b1;
                res.ctrl.fu_op      = decode_pkg::int_op_pass_src2;
                res.ctrl.src2_sel   = decode_pkg::src2_is_imm;
            end
            decode_pkg::op_auipc: begin
                res.hit             = 1'b1;
                res.ctrl.pipe_int_v = 1'b1;
                res.ctrl.irf_w_v    = 1'b1;
                res.ctrl.fu_op      = decode_pkg::int_op_add;
                res.ctrl.src1_sel   = decode_pkg::src1_is_pc;
                res.ctrl.src2_sel   = decode_pkg::src2_is_imm;
            end
            default: ;
        endcase
    end

endmodule

//--- hw/decode_mem.sv
// Combinational decoder for loads, stores, FENCE and FENCE.I into the mem pipe
`timescale 1ns/1ps

module decode_mem (
    input  decode_pkg::instr_t       instr,
    output decode_pkg::unit_result_s res
);

    decode_pkg::opcode_t opcode;
    decode_pkg::funct3_t funct3;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    always_comb begin
        res = '0;
        case (opcode)
            decode_pkg::op_load: begin
                res.hit             = 1'b1;
                res.ctrl.pipe_mem_v = 1'b1;
                res.ctrl.mem_v      = 1'b1;
                res.ctrl.dcache_r_v = 1'b1;
                res.ctrl.irf_w_v    = 1'b1;
                case (funct3)
                    decode_pkg::f3_lb:  res.ctrl.fu_op = decode_pkg::mem_op_lb;
                    decode_pkg::f3_lh:  res.ctrl.fu_op = decode_pkg::mem_op_lh;
                    decode_pkg::f3_lw:  res.ctrl.fu_op = decode_pkg::mem_op_lw;
                    decode_pkg::f3_ld:  res.ctrl.fu_op = decode_pkg::mem_op_ld;
                    decode_pkg::f3_lbu: res.ctrl.fu_op = decode_pkg::mem_op_lbu;
                    decode_pkg::f3_lhu: res.ctrl.fu_op = decode_pkg::mem_op_lhu;
                    decode_pkg::f3_lwu: res.ctrl.fu_op = decode_pkg::mem_op_lwu;
                    default:            res.illegal    = 1'b1;
                endcase
            end
            decode_pkg::op_store: begin
                res.hit             = 1'b1;
                res.ctrl.pipe_mem_v = 1'b1;
                res.ctrl.mem_v      = 1'b1;
                res.ctrl.dcache_w_v = 1'b1;
                case (funct3)
                    decode_pkg::f3_sb: res.ctrl.fu_op = decode_pkg::mem_op_sb;
                    decode_pkg::f3_sh: res.ctrl.fu_op = decode_pkg::mem_op_sh;
                    decode_pkg::f3_sw: res.ctrl.fu_op = decode_pkg::mem_op_sw;
                    decode_pkg::f3_sd: res.ctrl.fu_op = decode_pkg::mem_op_sd;
                    default:           res.illegal    = 1'b1;
                endcase
            end
            decode_pkg::op_misc_mem: begin
                res.hit = 1'b1;
                case (funct3)
                    // Memory is already ordered, so FENCE issues nothing
                    decode_pkg::f3_fence: ;
                    decode_pkg::f3_fence_i: begin
                        res.ctrl.pipe_mem_v = 1'b1;
                        res.ctrl.dcache_w_v = 1'b1;
                        res.ctrl.serial_v   = 1'b1;
                        res.ctrl.fu_op      = decode_pkg::mem_op_fencei;
                    end
                    default: res.illegal = 1'b1;
                endcase
            end
            default: ;
        endcase
    end

endmodule

//--- hw/decode_pkg.sv
// Shared widths, RV64 encodings, operation codes and control word structs for the decoder
package decode_pkg;

    localparam int instr_width  = 32;
    localparam int opcode_width = 7;
    localparam int funct3_width = 3;
    localparam int funct7_width = 7;
    localparam int fu_op_width  = 5;
    localparam int fe_exc_width = 2;

    typedef logic [instr_width-1:0]  instr_t;
    typedef logic [opcode_width-1:0] opcode_t;
    typedef logic [funct3_width-1:0] funct3_t;
    typedef logic [funct7_width-1:0] funct7_t;
    typedef logic [fu_op_width-1:0]  fu_op_t;
    typedef logic [fe_exc_width-1:0] fe_exc_code_t;
    typedef logic                    src1_sel_t;
    typedef logic                    src2_sel_t;
    typedef logic                    baddr_sel_t;

    // Major opcodes
    localparam opcode_t op_load     = 7'b0000011;
    localparam opcode_t op_misc_mem = 7'b0001111;
    localparam opcode_t op_imm      = 7'b0010011;
    localparam opcode_t op_auipc    = 7'b0010111;
    localparam opcode_t op_imm_32   = 7'b0011011;
    localparam opcode_t op_store    = 7'b0100011;
    localparam opcode_t op_op       = 7'b0110011;
    localparam opcode_t op_lui      = 7'b0110111;
    localparam opcode_t op_op_32    = 7'b0111011;
    localparam opcode_t op_branch   = 7'b1100011;
    localparam opcode_t op_jalr     = 7'b1100111;
    localparam opcode_t op_jal      = 7'b1101111;

    localparam funct7_t funct7_base   = 7'b0000000;
    localparam funct7_t funct7_alt    = 7'b0100000;
    localparam funct7_t funct7_muldiv = 7'b0000001;

    // Integer funct3
    localparam funct3_t f3_add_sub = 3'd0;
    localparam funct3_t f3_sll     = 3'd1;
    localparam funct3_t f3_slt     = 3'd2;
    localparam funct3_t f3_sltu    = 3'd3;
    localparam funct3_t f3_xor     = 3'd4;
    localparam funct3_t f3_srl_sra = 3'd5;
    localparam funct3_t f3_or      = 3'd6;
    localparam funct3_t f3_and     = 3'd7;

    // M extension funct3 without the MULH forms
    localparam funct3_t f3_mul  = 3'd0;
    localparam funct3_t f3_div  = 3'd4;
    localparam funct3_t f3_divu = 3'd5;
    localparam funct3_t f3_rem  = 3'd6;
    localparam funct3_t f3_remu = 3'd7;

    localparam funct3_t f3_jalr = 3'd0;
    localparam funct3_t f3_beq  = 3'd0;
    localparam funct3_t f3_bne  = 3'd1;
    localparam funct3_t f3_blt  = 3'd4;
    localparam funct3_t f3_bge  = 3'd5;
    localparam funct3_t f3_bltu = 3'd6;
    localparam funct3_t f3_bgeu = 3'd7;

    localparam funct3_t f3_lb  = 3'd0;
    localparam funct3_t f3_lh  = 3'd1;
    localparam funct3_t f3_lw  = 3'd2;
    localparam funct3_t f3_ld  = 3'd3;
    localparam funct3_t f3_lbu = 3'd4;
    localparam funct3_t f3_lhu = 3'd5;
    localparam funct3_t f3_lwu = 3'd6;

    localparam funct3_t f3_sb = 3'd0;
    localparam funct3_t f3_sh = 3'd1;
    localparam funct3_t f3_sw = 3'd2;
    localparam funct3_t f3_sd = 3'd3;

    localparam funct3_t f3_fence   = 3'd0;
    localparam funct3_t f3_fence_i = 3'd1;

    // Int pipe ops
    localparam fu_op_t int_op_add       = 5'b00000;
    localparam fu_op_t int_op_sll       = 5'b00001;
    localparam fu_op_t int_op_slt       = 5'b00010;
    localparam fu_op_t int_op_sltu      = 5'b00011;
    localparam fu_op_t int_op_xor       = 5'b00100;
    localparam fu_op_t int_op_srl       = 5'b00101;
    localparam fu_op_t int_op_or        = 5'b00110;
    localparam fu_op_t int_op_and       = 5'b00111;
    localparam fu_op_t int_op_sub       = 5'b01000;
    localparam fu_op_t int_op_sra       = 5'b01101;
    localparam fu_op_t int_op_pass_src2 = 5'b01111;

    // Mul and long pipe ops
    localparam fu_op_t mul_op_mul  = 5'b00000;
    localparam fu_op_t mul_op_div  = 5'b00001;
    localparam fu_op_t mul_op_divu = 5'b00010;
    localparam fu_op_t mul_op_rem  = 5'b00011;
    localparam fu_op_t mul_op_remu = 5'b00100;

    // Ctrl pipe ops
    localparam fu_op_t ctrl_op_beq  = 5'b00000;
    localparam fu_op_t ctrl_op_bne  = 5'b00001;
    localparam fu_op_t ctrl_op_blt  = 5'b00010;
    localparam fu_op_t ctrl_op_bge  = 5'b00011;
    localparam fu_op_t ctrl_op_bltu = 5'b00100;
    localparam fu_op_t ctrl_op_bgeu = 5'b00101;
    localparam fu_op_t ctrl_op_jal  = 5'b00110;
    localparam fu_op_t ctrl_op_jalr = 5'b00111;

    // Mem pipe ops
    localparam fu_op_t mem_op_lb     = 5'b00000;
    localparam fu_op_t mem_op_lh     = 5'b00001;
    localparam fu_op_t mem_op_lw     = 5'b00010;
    localparam fu_op_t mem_op_ld     = 5'b00011;
    localparam fu_op_t mem_op_lbu    = 5'b00100;
    localparam fu_op_t mem_op_lhu    = 5'b00101;
    localparam fu_op_t mem_op_lwu    = 5'b00110;
    localparam fu_op_t mem_op_sb     = 5'b01000;
    localparam fu_op_t mem_op_sh     = 5'b01001;
    localparam fu_op_t mem_op_sw     = 5'b01010;
    localparam fu_op_t mem_op_sd     = 5'b01011;
    localparam fu_op_t mem_op_fencei = 5'b10000;

    localparam src1_sel_t  src1_is_rs1  = 1'b0;
    localparam src1_sel_t  src1_is_pc   = 1'b1;
    localparam src2_sel_t  src2_is_rs2  = 1'b0;
    localparam src2_sel_t  src2_is_imm  = 1'b1;
    localparam baddr_sel_t baddr_is_pc  = 1'b0;
    localparam baddr_sel_t baddr_is_rs1 = 1'b1;

    localparam fe_exc_code_t fe_exc_access_fault = 2'd0;
    localparam fe_exc_code_t fe_exc_page_fault   = 2'd1;
    localparam fe_exc_code_t fe_exc_itlb_miss    = 2'd2;

    // 24-bit control word with the MSB first
    typedef struct packed {
        logic       instr_v;
        logic       pipe_ctrl_v;
        logic       pipe_int_v;
        logic       pipe_mem_v;
        logic       pipe_mul_v;
        logic       pipe_long_v;
        logic       irf_w_v;
        logic       dcache_r_v;
        logic       dcache_w_v;
        logic       mem_v;
        logic       serial_v;
        logic       opw_v;
        fu_op_t     fu_op;
        src1_sel_t  src1_sel;
        src2_sel_t  src2_sel;
        baddr_sel_t baddr_sel;
        logic       illegal_instr;
        logic       instr_access_fault;
        logic       instr_page_fault;
        logic       itlb_miss;
    } decode_s;

    typedef struct packed {
        logic    hit;
        logic    illegal;
        decode_s ctrl;
    } unit_result_s;

endpackage

//--- hw/instr_decoder.sv
// Top-level registered decoder merging the unit decoders with illegal and fault override
`timescale 1ns/1ps

module instr_decoder (
    input  logic                      clk_i,
    input  logic                      reset,
    input  logic                      in_v,
    input  decode_pkg::instr_t        instr,
    input  logic                      fe_exc_v,
    input  decode_pkg::fe_exc_code_t  fe_exc_code,
    output logic                      out_v,
    output decode_pkg::decode_s       decode
);

    decode_pkg::unit_result_s int_res;
    decode_pkg::unit_result_s ctrl_res;
    decode_pkg::unit_result_s mem_res;
    decode_pkg::decode_s      merged;
    decode_pkg::decode_s      decode_n;
    logic                     any_hit;
    logic                     is_illegal;

    decode_int u_decode_int (
        .instr (instr),
        .res   (int_res)
    );

    decode_ctrl u_decode_ctrl (
        .instr (instr),
        .res   (ctrl_res)
    );

    decode_mem u_decode_mem (
        .instr (instr),
        .res   (mem_res)
    );

    // Units that miss drive zeros, so a plain OR picks the owner
    assign merged     = int_res.ctrl | ctrl_res.ctrl | mem_res.ctrl;
    assign any_hit    = int_res.hit | ctrl_res.hit | mem_res.hit;
    assign is_illegal = ~any_hit | int_res.illegal | ctrl_res.illegal | mem_res.illegal;

    always_comb begin
        decode_n         = merged;
        decode_n.instr_v = 1'b1;
        // Front-end fault wins over an illegal encoding
        if (fe_exc_v) begin
            decode_n = '0;
            case (fe_exc_code)
                decode_pkg::fe_exc_access_fault: decode_n.instr_access_fault = 1'b1;
                decode_pkg::fe_exc_page_fault:   decode_n.instr_page_fault   = 1'b1;
                decode_pkg::fe_exc_itlb_miss:    decode_n.itlb_miss          = 1'b1;
                default: ;
            endcase
        end else if (is_illegal) begin
            decode_n               = '0;
            decode_n.illegal_instr = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset) begin
            out_v  <= 1'b0;
            decode <= '0;
        end else begin
            out_v <= in_v;
            // Hold the last word when no strobe arrives
            if (in_v) begin
                decode <= decode_n;
            end
        end
    end

endmodule

//--- sim.f
hw/decode_pkg.sv
hw/decode_int.sv
hw/decode_ctrl.sv
hw/decode_mem.sv
hw/instr_decoder.sv
sim/clock_gen.sv
sim/tb_instr_decoder.sv

//--- sim/clock_gen.sv
// Testbench clock at a 10 ns period and a synchronous reset held for the first two cycles
`timescale 1ns/1ps

module clock_gen (
    output logic clk_i,
    output logic reset
);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk_i);
        reset <= 1'b0;
    end

endmodule

//--- sim/decode_trace.txt
# name in_v instr_hex fe_exc_v fe_exc_code expected_decode_hex (gap rows expect the held word)
add          1 003100B3 0 0 A20000
sub          1 403100B3 0 0 A20400
sra          1 403150B3 0 0 A20680
srai         1 42115093 0 0 A206A0
addw         1 003100BB 0 0 A21000
subw         1 403100BB 0 0 A21400
sraiw        1 4031509B 0 0 A216A0
lui          1 123450B7 0 0 A207A0
auipc        1 00001097 0 0 A20060
gap          0 00000000 0 0 A20060
mul          1 023100B3 0 0 8A0000
mulw         1 023100BB 0 0 8A1000
div          1 023140B3 0 0 840080
divuw        1 023150BB 0 0 841100
remw         1 023160BB 0 0 841180
remu         1 023170B3 0 0 840200
jal          1 100000EF 0 0 C20300
jalr         1 000100E7 0 0 C20390
beq          1 00310463 0 0 C00000
bne          1 00311463 0 0 C00080
blt          1 00314463 0 0 C00100
bge          1 00315463 0 0 C00180
bltu         1 00316463 0 0 C00200
bgeu         1 00317463 0 0 C00280
lb           1 00010083 0 0 934000
lh           1 00011083 0 0 934080
lw           1 00012083 0 0 934100
ld           1 00013083 0 0 934180
lbu          1 00014083 0 0 934200
lhu          1 00015083 0 0 934280
lwu          1 00016083 0 0 934300
sb           1 00310023 0 0 90C400
sh           1 00311023 0 0 90C480
sw           1 00312023 0 0 90C500
sd           1 00313023 0 0 90C580
fence        1 0FF0000F 0 0 800000
fence_i      1 0000100F 0 0 90A800
bad_opcode   1 0000007F 0 0 000008
jalr_f3      1 000110E7 0 0 000008
branch_f3_2  1 00312463 0 0 000008
store_f3     1 00314023 0 0 000008
op_funct7    1 203100B3 0 0 000008
system_ecall 1 00000073 0 0 000008
amo_add      1 0031202F 0 0 000008
exc_access   1 003100B3 1 0 000004
exc_page     1 00000073 1 1 000002
exc_itlb     1 00012083 1 2 000001

//--- sim/tb_instr_decoder.sv
// Trace-driven testbench for the registered decoder, compiled from sim.f as the simulation top
`timescale 1ns/1ps

module tb_instr_decoder;

    logic                     clk_i;
    logic                     reset;
    logic                     in_v;
    decode_pkg::instr_t       instr;
    logic                     fe_exc_v;
    decode_pkg::fe_exc_code_t fe_exc_code;
    logic                     out_v;
    decode_pkg::decode_s      decode;

    string                    names[$];
    logic                     vec_v[$];
    decode_pkg::instr_t       vec_instr[$];
    logic                     vec_exc_v[$];
    decode_pkg::fe_exc_code_t vec_exc_code[$];
    decode_pkg::decode_s      vec_expect[$];
    int                       pending[$];
    int                       pass_count;
    int                       fail_count;
    int                       cycle_count;
    int                       cycle_limit;
    int                       idx;
    int                       chk;
    logic                     loaded;

    clock_gen u_clock_gen (
        .clk_i (clk_i),
        .reset (reset)
    );

    instr_decoder uut (
        .clk_i       (clk_i),
        .reset       (reset),
        .in_v        (in_v),
        .instr       (instr),
        .fe_exc_v    (fe_exc_v),
        .fe_exc_code (fe_exc_code),
        .out_v       (out_v),
        .decode      (decode)
    );

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual,
                               output logic ok);
        ok = (actual === expected);
        if (!ok) begin
            $display("[FAIL] %0s %0s expected 0x%06h actual 0x%06h",
                     test, what, expected, actual);
        end
    endtask

    task automatic check_outputs(input string test, input logic exp_v,
                                 input decode_pkg::decode_s exp_word);
        logic ok_v;
        logic ok_d;
        check_value(test, "out_v", {31'd0, exp_v}, {31'd0, out_v}, ok_v);
        check_value(test, "decode", {8'd0, exp_word}, {8'd0, decode}, ok_d);
        if (ok_v && ok_d) begin
            pass_count++;
            $display("%0s: pass", test);
        end else begin
            fail_count++;
            $display("%0s: fail", test);
        end
    endtask

    task automatic load_trace(output logic ok);
        int          fd;
        int          rc;
        int          v;
        int          ev;
        int          ec;
        string       line;
        string       name;
        logic [31:0] word;
        logic [31:0] exp_word;
        ok = 1'b1;
        fd = $fopen("sim/decode_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file sim/decode_trace.txt");
            ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                // Comments and blank lines
                if (rc > 1 && line.getc(0) != "#") begin
                    rc = $sscanf(line, "%s %d %h %d %d %h", name, v, word, ev, ec, exp_word);
                    if (rc == 6) begin
                        names.push_back(name);
                        vec_v.push_back(v[0]);
                        vec_instr.push_back(word);
                        vec_exc_v.push_back(ev[0]);
                        vec_exc_code.push_back(ec[1:0]);
                        vec_expect.push_back(exp_word[23:0]);
                    end else begin
                        $display("Malformed trace line: %0s", line);
                        ok = 1'b0;
                    end
                end
            end
            $fclose(fd);
            if (names.size() == 0) begin
                $display("The trace file holds no vectors");
                ok = 1'b0;
            end
        end
    endtask

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the trace did not complete", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        in_v        = 1'b0;
        instr       = '0;
        fe_exc_v    = 1'b0;
        fe_exc_code = '0;
        load_trace(loaded);
        if (!loaded) begin
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            cycle_limit = 2 * names.size() + 20;
            wait (reset == 1'b0);
            @(negedge clk_i);
            check_outputs("reset", 1'b0, '0);
            for (idx = 0; idx < names.size(); idx++) begin
                @(posedge clk_i);
                in_v        <= vec_v[idx];
                instr       <= vec_instr[idx];
                fe_exc_v    <= vec_exc_v[idx];
                fe_exc_code <= vec_exc_code[idx];
                pending.push_back(idx);
                @(negedge clk_i);
                // Previous vector has been registered by now
                if (pending.size() > 1) begin
                    chk = pending.pop_front();
                    check_outputs(names[chk], vec_v[chk], vec_expect[chk]);
                end
            end
            @(posedge clk_i);
            in_v     <= 1'b0;
            fe_exc_v <= 1'b0;
            @(negedge clk_i);
            chk = pending.pop_front();
            check_outputs(names[chk], vec_v[chk], vec_expect[chk]);
            $display("%0d tests, %0d passed, %0d failed",
                     pass_count + fail_count, pass_count, fail_count);
            if (fail_count == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule
